// ==== tetris_grid_pkg.sv ====
package tetris_grid_pkg;

  //////////////////////////////////////////////////////////////////////
  // playfield geometry
  //////////////////////////////////////////////////////////////////////

  localparam int GRID_ROWS = 22;
  localparam int GRID_COLS = 10;

  typedef logic [2:0] cell_t;              // colour code, 0 is empty
  typedef cell_t [GRID_COLS-1:0] row_t;
  typedef row_t  [GRID_ROWS-1:0] grid_t;   // grid[row][col], row 0 on top

  typedef logic [4:0] row_idx_t;
  // box column, values 12..15 stand for -4..-1 left of the wall
  typedef logic [3:0] col_idx_t;
  typedef logic [7:0] line_cnt_t;

  localparam cell_t    CELL_EMPTY = 3'd0;
  localparam row_idx_t LAST_ROW   = row_idx_t'(GRID_ROWS - 1);
  localparam col_idx_t LAST_COL   = col_idx_t'(GRID_COLS - 1);

  // a row counts as full when no cell is empty
  function automatic logic row_full(row_t r);
    logic full;
    full = 1'b1;
    for (int c = 0; c < GRID_COLS; c++) begin
      if (r[c] == CELL_EMPTY) begin
        full = 1'b0;
      end
    end
    return full;
  endfunction

endpackage

// ==== tetris_ctrl_pkg.sv ====
package tetris_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE, SPAWN, FALL, MOVE_CHECK, LOCK, CLEAR, GAME_OVER
  } state_t;

  typedef enum logic [2:0] {
    M_LEFT, M_RIGHT, M_ROR, M_DOWN, M_NONE
  } move_t;

  typedef logic [2:0] shape_t;
  typedef logic [1:0] rot_t;

  localparam shape_t SH_O = 3'd0;
  localparam shape_t SH_I = 3'd1;
  localparam shape_t SH_T = 3'd2;
  localparam shape_t SH_S = 3'd3;
  localparam shape_t SH_Z = 3'd4;
  localparam shape_t SH_J = 3'd5;
  localparam shape_t SH_L = 3'd6;

  localparam tetris_grid_pkg::row_idx_t SPAWN_ROW = 5'd0;
  localparam tetris_grid_pkg::col_idx_t SPAWN_COL = 4'd3;

  // row and col are the top-left corner of the 4x4 box
  typedef struct packed {
    shape_t                    shape;
    rot_t                      rot;
    tetris_grid_pkg::row_idx_t row;
    tetris_grid_pkg::col_idx_t col;
    tetris_grid_pkg::cell_t    color;
  } piece_t;

  // 4x4 box mask, msb is box row 0 col 0, one nibble per box row
  function automatic logic [15:0] shape_mask(shape_t shape, rot_t rot);
    logic [63:0] all_rot;            // {rot3, rot2, rot1, rot0}
    case (shape)
      SH_O:    all_rot = 64'h6600_6600_6600_6600;
      SH_I:    all_rot = 64'h4444_00F0_2222_0F00;
      SH_T:    all_rot = 64'h4C40_0E40_4640_4E00;
      SH_S:    all_rot = 64'h8C40_06C0_4620_6C00;
      SH_Z:    all_rot = 64'h4C80_0C60_2640_C600;
      SH_J:    all_rot = 64'h44C0_0E20_6440_8E00;
      SH_L:    all_rot = 64'hC440_0E80_4460_2E00;
      default: all_rot = '0;
    endcase
    return all_rot[16*rot +: 16];
  endfunction

  function automatic logic box_bit(logic [15:0] mask, int br, int bc);
    return mask[15 - 4*br - bc];
  endfunction

endpackage

// ==== piece_source.sv ====
`timescale 1ns/1ps

module piece_source (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    next_i,
  output tetris_ctrl_pkg::shape_t shape_o,
  output tetris_grid_pkg::cell_t  color_o
);

  import tetris_grid_pkg::*;
  import tetris_ctrl_pkg::*;

  shape_t shape_q;     // shape dealt on the next request
  cell_t  color_q;
  shape_t shape_nxt;

  // fixed order O I T S Z J L, then back to O
  assign shape_nxt = (shape_q == SH_L) ? SH_O : shape_q + 3'd1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shape_q <= SH_O;
      color_q <= cell_t'(SH_O + 3'd1);
    end else if (next_i) begin
      shape_q <= shape_nxt;
      color_q <= cell_t'(shape_nxt + 3'd1);   // colour follows the shape id
    end
  end

  assign shape_o = shape_q;
  assign color_o = color_q;

endmodule

// ==== piece_mover.sv ====
`timescale 1ns/1ps

module piece_mover (
  input  tetris_ctrl_pkg::piece_t piece_i,
  input  tetris_ctrl_pkg::move_t  move_i,
  input  tetris_grid_pkg::grid_t  grid_i,
  output tetris_ctrl_pkg::piece_t cand_o,
  output logic                    collide_o
);

  import tetris_grid_pkg::*;
  import tetris_ctrl_pkg::*;

  piece_t      cand;
  logic [15:0] mask;
  row_idx_t    cell_r;
  col_idx_t    cell_c;

  //////////////////////////////////////////////////////////////////////
  // candidate position
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cand = piece_i;
    case (move_i)
      M_LEFT: begin
        cand.col = piece_i.col - 4'd1;   // may wrap below column 0
      end
      M_RIGHT: begin
        cand.col = piece_i.col + 4'd1;
      end
      M_ROR: begin
        cand.rot = piece_i.rot + 2'd1;
      end
      M_DOWN: begin
        cand.row = piece_i.row + 5'd1;
      end
      default: begin
        cand = piece_i;                  // test in place
      end
    endcase
  end

  assign mask   = shape_mask(cand.shape, cand.rot);
  assign cand_o = cand;

  //////////////////////////////////////////////////////////////////////
  // collision test over the 4x4 box
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    collide_o = 1'b0;
    cell_r    = '0;
    cell_c    = '0;
    for (int br = 0; br < 4; br++) begin
      for (int bc = 0; bc < 4; bc++) begin
        cell_r = cand.row + row_idx_t'(br);
        cell_c = cand.col + col_idx_t'(bc);   // negative columns land on 12..15
        if (box_bit(mask, br, bc)) begin
          if (cell_c > LAST_COL || cell_r > LAST_ROW) begin
            collide_o = 1'b1;                  // wall or floor
          end else if (grid_i[cell_r][cell_c] != CELL_EMPTY) begin
            collide_o = 1'b1;                  // settled block
          end
        end
      end
    end
  end

endmodule

// ==== line_clear.sv ====
`timescale 1ns/1ps

module line_clear (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start_i,
  input  tetris_grid_pkg::grid_t    grid_i,
  output tetris_grid_pkg::grid_t    grid_o,
  output tetris_grid_pkg::row_idx_t removed_o,
  output logic                      done_o
);

  import tetris_grid_pkg::*;

  typedef enum logic [1:0] {
    CL_IDLE,
    CL_SCAN,   // one row per cycle, bottom up
    CL_FILL    // blank the vacated top rows
  } clr_state_t;

  clr_state_t state_q;
  grid_t      work_q;
  row_idx_t   rd_q;        // row being examined
  row_idx_t   wr_q;        // next row to keep
  row_idx_t   removed_q;
  logic       done_q;
  logic       rd_full;

  assign rd_full = row_full(work_q[rd_q]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= CL_IDLE;
      rd_q      <= '0;
      wr_q      <= '0;
      removed_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CL_IDLE: begin
          if (start_i) begin
            state_q   <= CL_SCAN;
            rd_q      <= LAST_ROW;
            wr_q      <= LAST_ROW;
            removed_q <= '0;
          end
        end
        CL_SCAN: begin
          if (rd_full) begin
            removed_q <= removed_q + 5'd1;   // skip it, write index holds
          end else begin
            wr_q <= wr_q - 5'd1;
          end
          rd_q <= rd_q - 5'd1;
          if (rd_q == '0) begin
            state_q <= CL_FILL;
          end
        end
        CL_FILL: begin
          done_q  <= 1'b1;
          state_q <= CL_IDLE;
        end
        default: begin
          state_q <= CL_IDLE;
        end
      endcase
    end
  end

  // working copy of the grid
  always_ff @(posedge clk) begin
    if (state_q == CL_IDLE && start_i) begin
      work_q <= grid_i;
    end else if (state_q == CL_SCAN && !rd_full) begin
      work_q[wr_q] <= work_q[rd_q];          // shift kept row down
    end else if (state_q == CL_FILL) begin
      for (int i = 0; i < GRID_ROWS; i++) begin
        if (row_idx_t'(i) < removed_q) begin
          work_q[i] <= '0;
        end
      end
    end
  end

  assign grid_o    = work_q;
  assign removed_o = removed_q;
  assign done_o    = done_q;

endmodule

// ==== tetris_fsm.sv ====
`timescale 1ns/1ps

module tetris_fsm (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  logic                       step_i,
  input  logic                       left_i,
  input  logic                       right_i,
  input  logic                       rot_i,
  input  tetris_ctrl_pkg::shape_t    shape_i,
  input  tetris_grid_pkg::cell_t     color_i,
  input  tetris_ctrl_pkg::piece_t    cand_i,
  input  logic                       collide_i,
  input  tetris_grid_pkg::grid_t     clr_grid_i,
  input  tetris_grid_pkg::row_idx_t  clr_removed_i,
  input  logic                       clr_done_i,
  output logic                       next_piece_o,
  output tetris_ctrl_pkg::piece_t    piece_o,
  output tetris_ctrl_pkg::move_t     move_o,
  output tetris_grid_pkg::grid_t     settled_o,
  output logic                       clr_start_o,
  output tetris_grid_pkg::grid_t     grid_o,
  output tetris_ctrl_pkg::state_t    state_o,
  output tetris_grid_pkg::line_cnt_t lines_o,
  output logic                       game_over_o
);

  import tetris_grid_pkg::*;
  import tetris_ctrl_pkg::*;

  state_t      state_q;
  grid_t       settled_q;
  piece_t      active_q;
  move_t       move_q;       // move under test in MOVE_CHECK
  line_cnt_t   lines_q;
  logic        clr_start_q;

  piece_t      spawn_piece;
  move_t       step_move;
  grid_t       painted;      // settled grid with the active piece drawn in
  logic [15:0] active_mask;
  row_idx_t    cell_r;
  col_idx_t    cell_c;

  //////////////////////////////////////////////////////////////////////
  // piece and move selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    spawn_piece       = '0;
    spawn_piece.shape = shape_i;
    spawn_piece.rot   = '0;
    spawn_piece.row   = SPAWN_ROW;
    spawn_piece.col   = SPAWN_COL;
    spawn_piece.color = color_i;
  end

  // left over right over rotate, down otherwise
  always_comb begin
    if (left_i) begin
      step_move = M_LEFT;
    end else if (right_i) begin
      step_move = M_RIGHT;
    end else if (rot_i) begin
      step_move = M_ROR;
    end else begin
      step_move = M_DOWN;
    end
  end

  assign piece_o      = (state_q == SPAWN) ? spawn_piece : active_q;
  assign move_o       = (state_q == MOVE_CHECK) ? move_q : M_NONE;
  assign next_piece_o = (state_q == SPAWN);

  //////////////////////////////////////////////////////////////////////
  // active piece overlay, also the value written on lock
  //////////////////////////////////////////////////////////////////////

  assign active_mask = shape_mask(active_q.shape, active_q.rot);

  always_comb begin
    painted = settled_q;
    cell_r  = '0;
    cell_c  = '0;
    for (int br = 0; br < 4; br++) begin
      for (int bc = 0; bc < 4; bc++) begin
        cell_r = active_q.row + row_idx_t'(br);
        cell_c = active_q.col + col_idx_t'(bc);
        if (box_bit(active_mask, br, bc) && cell_r <= LAST_ROW && cell_c <= LAST_COL) begin
          painted[cell_r][cell_c] = active_q.color;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= IDLE;
      settled_q   <= '0;
      active_q    <= '0;
      move_q      <= M_NONE;
      lines_q     <= '0;
      clr_start_q <= 1'b0;
    end else begin
      clr_start_q <= (state_q == LOCK);     // one pulse on entry to CLEAR
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= SPAWN;
          end
        end
        SPAWN: begin
          if (collide_i) begin
            state_q <= GAME_OVER;           // no room at the top
          end else begin
            active_q <= spawn_piece;
            state_q  <= FALL;
          end
        end
        FALL: begin
          if (step_i) begin
            move_q  <= step_move;
            state_q <= MOVE_CHECK;
          end
        end
        MOVE_CHECK: begin
          if (!collide_i) begin
            active_q <= cand_i;
            state_q  <= FALL;
          end else if (move_q == M_DOWN) begin
            state_q <= LOCK;
          end else begin
            state_q <= FALL;                // blocked side move is dropped
          end
        end
        LOCK: begin
          settled_q <= painted;
          state_q   <= CLEAR;
        end
        CLEAR: begin
          if (clr_done_i) begin
            settled_q <= clr_grid_i;
            lines_q   <= lines_q + line_cnt_t'(clr_removed_i);
            state_q   <= SPAWN;
          end
        end
        GAME_OVER: begin
          if (start_i) begin
            settled_q <= '0;
            lines_q   <= '0;
            state_q   <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign settled_o   = settled_q;
  assign clr_start_o = clr_start_q;
  assign grid_o      = (state_q == FALL || state_q == MOVE_CHECK) ? painted : settled_q;
  assign state_o     = state_q;
  assign lines_o     = lines_q;
  assign game_over_o = (state_q == GAME_OVER);

endmodule

// ==== tetris_top.sv ====
`timescale 1ns/1ps

module tetris_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  logic                       step_i,
  input  logic                       left_i,
  input  logic                       right_i,
  input  logic                       rot_i,
  output tetris_grid_pkg::grid_t     grid_o,
  output tetris_ctrl_pkg::state_t    state_o,
  output tetris_grid_pkg::line_cnt_t lines_o,
  output logic                       game_over_o
);

  import tetris_grid_pkg::*;
  import tetris_ctrl_pkg::*;

  // piece source
  logic     next_piece;
  shape_t   shape;
  cell_t    color;

  // mover
  piece_t   piece;
  move_t    move;
  piece_t   cand;
  logic     collide;
  grid_t    settled;

  // line clearer
  logic     clr_start;
  grid_t    clr_grid;
  row_idx_t clr_removed;
  logic     clr_done;

  tetris_fsm fsm_inst (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start_i),
    .step_i        (step_i),
    .left_i        (left_i),
    .right_i       (right_i),
    .rot_i         (rot_i),
    .shape_i       (shape),
    .color_i       (color),
    .cand_i        (cand),
    .collide_i     (collide),
    .clr_grid_i    (clr_grid),
    .clr_removed_i (clr_removed),
    .clr_done_i    (clr_done),
    .next_piece_o  (next_piece),
    .piece_o       (piece),
    .move_o        (move),
    .settled_o     (settled),
    .clr_start_o   (clr_start),
    .grid_o        (grid_o),
    .state_o       (state_o),
    .lines_o       (lines_o),
    .game_over_o   (game_over_o)
  );

  piece_source source_inst (
    .clk     (clk),
    .rst     (rst),
    .next_i  (next_piece),
    .shape_o (shape),
    .color_o (color)
  );

  piece_mover mover_inst (
    .piece_i   (piece),
    .move_i    (move),
    .grid_i    (settled),
    .cand_o    (cand),
    .collide_o (collide)
  );

  line_clear clear_inst (
    .clk       (clk),
    .rst       (rst),
    .start_i   (clr_start),
    .grid_i    (settled),
    .grid_o    (clr_grid),
    .removed_o (clr_removed),
    .done_o    (clr_done)
  );

endmodule

// ==== tetris_tb_checks.svh ====
`ifndef TETRIS_TB_CHECKS_SVH
`define TETRIS_TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// typed compares
//////////////////////////////////////////////////////////////////////

task automatic check_state(input state_t got, input state_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error at %0t ns: %s, state %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_cell(input grid_t g, input row_idx_t r, input col_idx_t c,
                          input cell_t exp, input string what);
  checks++;
  if (g[r][c] !== exp) begin
    errors++;
    $display("error at %0t ns: %s, cell (%0d,%0d) is %0d expected %0d",
             $time, what, r, c, g[r][c], exp);
  end
endtask

task automatic check_lines(input line_cnt_t got, input line_cnt_t exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error at %0t ns: %s, lines %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error at %0t ns: %s, flag %b expected %b", $time, what, got, exp);
  end
endtask

// whole visible grid must be blank
task automatic check_grid_empty(input string what);
  for (int r = 0; r < GRID_ROWS; r++) begin
    for (int c = 0; c < GRID_COLS; c++) begin
      check_cell(grid_o, row_idx_t'(r), col_idx_t'(c), CELL_EMPTY, what);
    end
  end
endtask

//////////////////////////////////////////////////////////////////////
// state waits, entered and left just after a falling edge
//////////////////////////////////////////////////////////////////////

task automatic wait_fall();
  while (state_o != FALL) @(negedge clk);
endtask

// piece in play again, or no room for it
task automatic wait_settle();
  while (state_o != FALL && state_o != GAME_OVER) @(negedge clk);
endtask

`endif

// ==== tetris_tb.sv ====
`timescale 1ns/1ps

module tetris_tb;

  import tetris_grid_pkg::*;
  import tetris_ctrl_pkg::*;

  typedef struct packed {
    row_idx_t r;
    col_idx_t c;
    cell_t    v;
  } cell_chk_t;

  // one row per piece: rotations first, then lefts, then rights, then drop
  typedef struct packed {
    logic [3:0] rots;
    logic [3:0] lefts;
    logic [3:0] rights;
    cell_chk_t  spawn;    // a cell of the freshly spawned piece
    line_cnt_t  lines;    // count once the piece has settled
    cell_chk_t  chk0;
    cell_chk_t  chk1;
    cell_chk_t  chk2;
    cell_chk_t  chk3;
  } step_t;

  localparam int NUM_STEPS     = 9;
  localparam int GO_MAX_PIECES = 30;   // drops allowed to fill the spawn area

  logic      clk;
  logic      rst;
  logic      start_i;
  logic      step_i;
  logic      left_i;
  logic      right_i;
  logic      rot_i;
  grid_t     grid_o;
  state_t    state_o;
  line_cnt_t lines_o;
  logic      game_over_o;

  step_t steps [NUM_STEPS];
  int    errors;
  int    checks;
  int    cycle_count = 0;
  int    cycle_limit;
  int    go_pieces;

  `include "tetris_tb_checks.svh"

  tetris_top tetris_top_inst (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .step_i      (step_i),
    .left_i      (left_i),
    .right_i     (right_i),
    .rot_i       (rot_i),
    .grid_o      (grid_o),
    .state_o     (state_o),
    .lines_o     (lines_o),
    .game_over_o (game_over_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  function automatic cell_chk_t cell_at(input int r, input int c, input int v);
    cell_chk_t k;
    k.r = row_idx_t'(r);
    k.c = col_idx_t'(c);
    k.v = cell_t'(v);
    return k;
  endfunction

  function automatic step_t make_step(input int rots, input int lefts, input int rights,
                                      input cell_chk_t spawn, input int lines,
                                      input cell_chk_t k0, input cell_chk_t k1,
                                      input cell_chk_t k2, input cell_chk_t k3);
    step_t s;
    s.rots   = rots[3:0];
    s.lefts  = lefts[3:0];
    s.rights = rights[3:0];
    s.spawn  = spawn;
    s.lines  = line_cnt_t'(lines);
    s.chk0   = k0;
    s.chk1   = k1;
    s.chk2   = k2;
    s.chk3   = k3;
    return s;
  endfunction

  // pieces come O I T S Z J L O I, colour = shape index + 1
  task automatic load_steps();
    steps[0] = make_step(0, 5, 0, cell_at(0, 4, 1), 0,     // O hard against left wall
                         cell_at(20, 0, 1), cell_at(20, 1, 1),
                         cell_at(21, 0, 1), cell_at(21, 1, 1));
    steps[1] = make_step(0, 1, 0, cell_at(1, 3, 2), 0,     // flat I on the floor
                         cell_at(21, 2, 2), cell_at(21, 3, 2),
                         cell_at(21, 4, 2), cell_at(21, 5, 2));
    steps[2] = make_step(0, 0, 3, cell_at(0, 4, 3), 0,
                         cell_at(21, 6, 3), cell_at(21, 7, 3),
                         cell_at(21, 8, 3), cell_at(20, 7, 3));
    steps[3] = make_step(0, 1, 0, cell_at(0, 4, 4), 0,     // S rests on the I
                         cell_at(20, 2, 4), cell_at(20, 3, 4),
                         cell_at(19, 3, 4), cell_at(19, 4, 4));
    steps[4] = make_step(0, 3, 0, cell_at(0, 3, 5), 0,
                         cell_at(18, 0, 5), cell_at(18, 1, 5),
                         cell_at(19, 1, 5), cell_at(19, 2, 5));
    steps[5] = make_step(0, 0, 2, cell_at(0, 3, 6), 0,     // J hangs on the T bump
                         cell_at(18, 5, 6), cell_at(19, 5, 6),
                         cell_at(19, 6, 6), cell_at(19, 7, 6));
    steps[6] = make_step(0, 3, 0, cell_at(0, 5, 7), 0,
                         cell_at(16, 2, 7), cell_at(17, 0, 7),
                         cell_at(17, 1, 7), cell_at(17, 2, 7));
    steps[7] = make_step(0, 0, 3, cell_at(0, 4, 1), 0,
                         cell_at(17, 7, 1), cell_at(17, 8, 1),
                         cell_at(18, 7, 1), cell_at(18, 8, 1));
    // upright I pushed past the right wall closes row 21, all drops one row
    steps[8] = make_step(1, 0, 6, cell_at(1, 3, 2), 1,
                         cell_at(21, 9, 2), cell_at(19, 9, 2),
                         cell_at(18, 9, 0), cell_at(21, 2, 4));
  endtask

  // 40 cycles per strobe, 300 per piece, plus reset and restart
  function automatic int cycle_budget();
    int n_strobes;
    n_strobes = GO_MAX_PIECES * GRID_ROWS;
    for (int i = 0; i < NUM_STEPS; i++) begin
      n_strobes += int'(steps[i].rots) + int'(steps[i].lefts) + int'(steps[i].rights);
      n_strobes += GRID_ROWS;
    end
    return 40 * n_strobes + 300 * (NUM_STEPS + GO_MAX_PIECES) + 64;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // player actions
  //////////////////////////////////////////////////////////////////////

  task automatic apply_move(input logic l, input logic r, input logic ro);
    wait_fall();
    step_i  = 1'b1;
    left_i  = l;
    right_i = r;
    rot_i   = ro;
    @(negedge clk);
    step_i  = 1'b0;
    left_i  = 1'b0;
    right_i = 1'b0;
    rot_i   = 1'b0;
  endtask

  // plain steps until a down move is refused
  task automatic drop_piece();
    logic landed;
    landed = 1'b0;
    while (!landed) begin
      apply_move(1'b0, 1'b0, 1'b0);
      @(negedge clk);                 // move check resolved by now
      if (state_o != FALL) begin
        landed = 1'b1;
      end
    end
  endtask

  task automatic check_chk(input cell_chk_t k, input string what);
    check_cell(grid_o, k.r, k.c, k.v, what);
  endtask

  task automatic run_step(input int i);
    step_t s;
    s = steps[i];
    wait_settle();
    check_state(state_o, FALL, "piece spawned");
    check_flag(game_over_o, 1'b0, "game over flag during play");
    check_chk(s.spawn, "spawned piece");
    repeat (s.rots) apply_move(1'b0, 1'b0, 1'b1);
    repeat (s.lefts) apply_move(1'b1, 1'b0, 1'b0);
    repeat (s.rights) apply_move(1'b0, 1'b1, 1'b0);
    drop_piece();
    wait_settle();
    check_state(state_o, FALL, "next piece after lock");
    check_lines(lines_o, s.lines, "cleared lines");
    check_chk(s.chk0, "settled cell");
    check_chk(s.chk1, "settled cell");
    check_chk(s.chk2, "settled cell");
    check_chk(s.chk3, "settled cell");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    errors  = 0;
    checks  = 0;
    rst     = 1'b1;
    start_i = 1'b0;
    step_i  = 1'b0;
    left_i  = 1'b0;
    right_i = 1'b0;
    rot_i   = 1'b0;
    load_steps();
    cycle_limit = cycle_budget();

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_state(state_o, IDLE, "after reset");
    check_grid_empty("grid after reset");
    check_lines(lines_o, '0, "lines after reset");
    check_flag(game_over_o, 1'b0, "game over after reset");

    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    wait_settle();
    check_state(state_o, FALL, "first spawn");
    check_cell(grid_o, 5'd0, 4'd5, 3'd1, "first O piece");
    check_cell(grid_o, 5'd1, 4'd4, 3'd1, "first O piece");
    check_cell(grid_o, 5'd1, 4'd5, 3'd1, "first O piece");
    check_cell(grid_o, 5'd0, 4'd3, CELL_EMPTY, "left of first O piece");

    for (int i = 0; i < NUM_STEPS; i++) begin
      run_step(i);
    end

    // stack in the spawn columns until a spawn has no room
    go_pieces = 0;
    while (state_o == FALL && go_pieces < GO_MAX_PIECES) begin
      drop_piece();
      wait_settle();
      go_pieces++;
    end
    if (state_o != GAME_OVER) begin
      errors++;
      $display("game over was never reached after %0d drops", go_pieces);
    end
    check_flag(game_over_o, 1'b1, "game over flag");
    check_state(state_o, GAME_OVER, "stack at the top");
    check_lines(lines_o, 8'd1, "lines kept at game over");

    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    check_state(state_o, IDLE, "restart");
    check_grid_empty("grid after restart");
    check_lines(lines_o, '0, "lines after restart");
    check_flag(game_over_o, 1'b0, "game over after restart");

    $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
tetris_grid_pkg.sv
tetris_ctrl_pkg.sv
piece_source.sv
piece_mover.sv
line_clear.sv
tetris_fsm.sv
tetris_top.sv
tetris_tb.sv
